/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_flash_fetch
RTL_TOP    := flash_fetch_top
FILELIST   := sources.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_ARGS   := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* fetch_port.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_port (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req,
    input  logic [flash_pkg::FLASH_ADDR_BITS-1:0] addr,
    input  logic                                 data_ready,
    input  logic [7:0]                           rd_data,
    output logic                                 ack,
    output logic [7:0]                           data,
    output logic                                 start_read,
    output logic                                 keep_reading,
    output logic [flash_pkg::FLASH_ADDR_BITS-1:0] rd_addr
);
    import flash_pkg::*;

    logic                       miss_wait;
    logic                       pf_pending;
    logic                       buf_valid;
    logic [7:0]                 buf_data;
    logic [FLASH_ADDR_BITS-1:0] buf_tag;
    logic [FLASH_ADDR_BITS-1:0] pf_tag;
    logic                       new_req;
    logic                       hit;
    logic                       land_first;
    logic                       land_pf;

    // A request is new while it has neither been answered nor is waiting on the flash
    assign new_req    = req && !ack && !miss_wait;
    assign hit        = buf_valid && (buf_tag == addr);
    assign land_first = data_ready && miss_wait;
    // A new request on the same cycle wins and the prefetch byte is dropped
    assign land_pf    = data_ready && pf_pending && !new_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack          <= 1'b0;
            start_read   <= 1'b0;
            keep_reading <= 1'b0;
            miss_wait    <= 1'b0;
            pf_pending   <= 1'b0;
            buf_valid    <= 1'b0;
        end else begin
            start_read <= 1'b0;
            if (!req)
                ack <= 1'b0;
            if (new_req) begin
                // Fresh read, keep_reading low for the start pulse aborts any old one
                start_read   <= 1'b1;
                keep_reading <= 1'b0;
                if (hit) begin
                    ack        <= 1'b1;
                    buf_valid  <= 1'b0;
                    pf_pending <= 1'b1;
                end else begin
                    miss_wait  <= 1'b1;
                    pf_pending <= 1'b0;
                end
            end else if (start_read) begin
                keep_reading <= 1'b1;
            end else if (land_first) begin
                // The stream carries on to addr+1, which becomes the prefetch
                ack        <= 1'b1;
                miss_wait  <= 1'b0;
                pf_pending <= 1'b1;
            end else if (land_pf) begin
                buf_valid    <= 1'b1;
                pf_pending   <= 1'b0;
                keep_reading <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_req) begin
            pf_tag <= addr + FLASH_ADDR_BITS'(1);
            if (hit) begin
                data    <= buf_data;
                rd_addr <= addr + FLASH_ADDR_BITS'(1);
            end else begin
                rd_addr <= addr;
            end
        end
        if (land_first)
            data <= rd_data;
        if (land_pf) begin
            buf_data <= rd_data;
            buf_tag  <= pf_tag;
        end
    end

endmodule

`default_nettype wire

/* flash_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module flash_checker (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 req,
    input logic [flash_pkg::FLASH_ADDR_BITS-1:0] addr,
    input logic                                 ack,
    input logic [7:0]                           data,
    input logic                                 cs,
    input logic [3:0]                           io_oe
);
    import flash_pkg::*;

    int   checks = 0;
    int   errors = 0;
    int   idle_cycles = 0;
    logic ack_q = 1'b0;
    logic rst_q = 1'b0;
    logic req_seen = 1'b0;

    // Values seen at a rising edge were set at the one before
    always @(posedge clk) begin
        rst_q <= rst;
        ack_q <= ack;
        if (req)
            req_seen <= 1'b1;
        if (!rst)
            idle_cycles <= idle_cycles + 1;
        // Bus idle during reset, and again after the wake-up command until the first request
        if (rst_q || (!req_seen && idle_cycles > 20)) begin
            checks = checks + 1;
            if (ack !== 1'b0 || cs !== 1'b1 || io_oe !== 4'h0) begin
                errors = errors + 1;
                $display("ERR %0t: bus not idle, ack %b cs %b io_oe %h", $time, ack, cs, io_oe);
            end
        end
        if (ack === 1'b1 && ack_q === 1'b0) begin
            checks = checks + 1;
            if (!req) begin
                errors = errors + 1;
                $display("ERR %0t: ack rose while req was low, addr %h", $time, addr);
            end
            if (data !== tb_flash_fetch.u_model.content_byte(addr)) begin
                errors = errors + 1;
                $display("ERR %0t: addr %h returned %h, expected %h", $time, addr, data,
                         tb_flash_fetch.u_model.content_byte(addr));
            end
        end
        if (ack === 1'b0 && ack_q === 1'b1 && req) begin
            errors = errors + 1;
            $display("ERR %0t: ack fell while req was still high, addr %h", $time, addr);
        end
    end

endmodule

`default_nettype wire

/* flash_fetch_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module flash_fetch_properties (
    input logic       clk,
    input logic       rst,
    input logic       req,
    input logic       ack,
    input logic [7:0] data,
    input logic [1:0] rd_state,
    input logic       data_ready,
    input logic       keep_reading
);
    import flash_pkg::*;

    int fail_count = 0;

    // No byte escapes in the first cycle after the sequencer enters READING
    ready_in_reading: assert property (@(posedge clk) disable iff (rst)
        data_ready |-> (rd_state == RD_READING) && ($past(rd_state) == RD_READING))
    else begin
        fail_count++;
        $error("data_ready outside a running READING state");
    end

    no_ready_after_abort: assert property (@(posedge clk) disable iff (rst)
        !keep_reading |=> !data_ready)
    else begin
        fail_count++;
        $error("data_ready one cycle after keep_reading was low");
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req)
    else begin
        fail_count++;
        $error("ack rose without req");
    end

    data_known: assert property (@(posedge clk) disable iff (rst)
        ack |-> !$isunknown(data))
    else begin
        fail_count++;
        $error("data unknown while ack is high");
    end

endmodule

// The top level sees the client port directly and the sequencer state one level down
bind flash_fetch_top flash_fetch_properties u_props (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .ack          (ack),
    .data         (data),
    .rd_state     (u_flash_reader.state),
    .data_ready   (data_ready),
    .keep_reading (keep_reading)
);

`default_nettype wire

/* flash_fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module flash_fetch_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req,
    input  logic [flash_pkg::FLASH_ADDR_BITS-1:0] addr,
    input  logic [3:0]                           io_in,
    output logic                                 ack,
    output logic [7:0]                           data,
    output logic                                 cs,
    output logic                                 sclk,
    output logic [3:0]                           io_out,
    output logic [3:0]                           io_oe
);
    import flash_pkg::*;

    logic                       start_read;
    logic                       keep_reading;
    logic [FLASH_ADDR_BITS-1:0] rd_addr;
    logic                       data_ready;
    logic [FLASH_ADDR_BITS-1:0] active_addr;
    logic                       do_read;
    logic                       setup_done;
    logic                       byte_valid;
    logic [7:0]                 byte_data;

    fetch_port u_fetch_port (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .addr         (addr),
        .data_ready   (data_ready),
        .rd_data      (byte_data),
        .ack          (ack),
        .data         (data),
        .start_read   (start_read),
        .keep_reading (keep_reading),
        .rd_addr      (rd_addr)
    );

    flash_reader u_flash_reader (
        .clk          (clk),
        .rst          (rst),
        .addr         (rd_addr),
        .start_read   (start_read),
        .keep_reading (keep_reading),
        .setup_done   (setup_done),
        .byte_valid   (byte_valid),
        .data_ready   (data_ready),
        .active_addr  (active_addr),
        .do_read      (do_read)
    );

    qspi_flash u_qspi_flash (
        .clk        (clk),
        .rst        (rst),
        .addr       (active_addr),
        .do_read    (do_read),
        .io_in      (io_in),
        .setup_done (setup_done),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .cs         (cs),
        .sclk       (sclk),
        .io_out     (io_out),
        .io_oe      (io_oe)
    );

endmodule

`default_nettype wire

/* flash_model.sv */
`timescale 1ns/1ns
`default_nettype none

module flash_model (
    input  logic       cs,
    input  logic       sclk,
    input  logic [3:0] io_out,
    output logic [3:0] io_in
);
    import flash_pkg::*;

    flash_cmd_word_u            rx_word;
    logic [7:0]                 wake_sr;
    logic                       awake;
    logic                       cmd_ok;
    logic [FLASH_ADDR_BITS-1:0] base_addr;
    logic [7:0]                 cur_byte;
    int                         edges;
    int                         idx;

    // Stored content is the xor of the three address bytes plus a constant
    function automatic logic [7:0] content_byte(input logic [FLASH_ADDR_BITS-1:0] a);
        return (a[23:16] ^ a[15:8] ^ a[7:0]) + 8'h5A;
    endfunction

    initial begin
        io_in   = 4'h0;
        awake   = 1'b0;
        cmd_ok  = 1'b0;
        edges   = 0;
        wake_sr = 8'h00;
        rx_word = '0;
    end

    // The host changes the lines on sclk falling, so they are taken on sclk rising
    always @(posedge sclk or posedge cs) begin
        if (cs !== 1'b0) begin
            // cs high ends a transaction and the next one counts sclk edges from zero
            edges = 0;
        end else begin
            if (!awake) begin
                wake_sr = {wake_sr[6:0], io_out[0]};
                if (edges == 7 && wake_sr == CMD_WAKE)
                    awake = 1'b1;
            end else if (edges < 8) begin
                rx_word.nib = {rx_word.nib[6:0], io_out};
                if (edges == 7) begin
                    cmd_ok    = (rx_word.f.cmd == CMD_QUAD_READ);
                    base_addr = rx_word.f.addr;
                end
            end
            edges = edges + 1;
        end
    end

    // Data nibbles go out on sclk falling once the dummy clocks are through
    always @(negedge sclk) begin
        if (cs == 1'b0 && awake && edges >= 8 + DUMMY_CLKS) begin
            idx      = edges - 8 - DUMMY_CLKS;
            cur_byte = content_byte(base_addr + FLASH_ADDR_BITS'(idx / 2));
            if (!cmd_ok)
                io_in <= 4'hx;
            else if (idx % 2 == 0)
                io_in <= cur_byte[7:4];
            else
                io_in <= cur_byte[3:0];
        end
    end

endmodule

`default_nettype wire

/* flash_pkg.sv */
`default_nettype none

package flash_pkg;

    // Byte address space of the serial flash
    localparam int FLASH_ADDR_BITS = 24;

    // Quad I/O fast read, command and address both go out on four lines
    localparam logic [7:0] CMD_QUAD_READ = 8'hEB;
    // Release from deep power-down, shifted out on the single SI line
    localparam logic [7:0] CMD_WAKE = 8'hAB;

    // Number of sclk periods between the last address nibble and the first data nibble
    localparam int DUMMY_CLKS = 4;

    // Pin engine phases
    localparam logic [2:0] QS_WAKE     = 3'd0;
    localparam logic [2:0] QS_WAKE_GAP = 3'd1;
    localparam logic [2:0] QS_IDLE     = 3'd2;
    localparam logic [2:0] QS_CMD_ADDR = 3'd3;
    localparam logic [2:0] QS_DUMMY    = 3'd4;
    localparam logic [2:0] QS_DATA     = 3'd5;
    localparam logic [2:0] QS_END      = 3'd6;

    // Read sequencer states
    localparam logic [1:0] RD_IDLE     = 2'b00;
    localparam logic [1:0] RD_READING  = 2'b01;
    localparam logic [1:0] RD_NEW_ADDR = 2'b10;

    // Command byte followed by the address, also seen as eight nibbles for the quad lines
    typedef union packed {
        struct packed {
            logic [7:0]                 cmd;
            logic [FLASH_ADDR_BITS-1:0] addr;
        } f;
        logic [7:0][3:0] nib;
    } flash_cmd_word_u;

endpackage

`default_nettype wire

/* flash_reader.sv */
`timescale 1ns/1ns
`default_nettype none

// Starting a read: pulse start_read with keep_reading low and addr valid, then hold
// keep_reading high. The read stays pending until data_ready.
// Scheduling a read: raise start_read while a read is pending. It becomes pending
// itself at the next data_ready, and addr must stay put until then.
// Dropping keep_reading aborts everything and no data_ready follows.

module flash_reader (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [flash_pkg::FLASH_ADDR_BITS-1:0] addr,
    input  logic                                 start_read,
    input  logic                                 keep_reading,
    input  logic                                 setup_done,
    input  logic                                 byte_valid,
    output logic                                 data_ready,
    output logic [flash_pkg::FLASH_ADDR_BITS-1:0] active_addr,
    output logic                                 do_read
);
    import flash_pkg::*;

    logic [1:0] state;
    logic       read_scheduled;
    logic       load_addr;

    // The pin engine only runs once its wake-up sequence is through
    assign do_read    = (state == RD_READING) && setup_done;
    assign data_ready = byte_valid && keep_reading && (state == RD_READING);

    // Cases in which the FSM below moves to a new address
    assign load_addr = start_read && (!keep_reading || state == RD_IDLE)
                     || (keep_reading && state == RD_READING && data_ready
                         && (start_read || read_scheduled));

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= RD_IDLE;
            read_scheduled <= 1'b0;
        end else if (!keep_reading) begin
            read_scheduled <= 1'b0;
            if (start_read) begin
                // A running transaction must end before the new address goes out
                if (do_read)
                    state <= RD_NEW_ADDR;
                else
                    state <= RD_READING;
            end else begin
                state <= RD_IDLE;
            end
        end else begin
            case (state)
                RD_IDLE: begin
                    if (start_read)
                        state <= RD_READING;
                end
                RD_READING: begin
                    if (data_ready) begin
                        if (start_read || read_scheduled) begin
                            read_scheduled <= 1'b0;
                            state          <= RD_NEW_ADDR;
                        end
                    end else if (start_read) begin
                        read_scheduled <= 1'b1;
                    end
                end
                RD_NEW_ADDR: begin
                    // do_read is low for this one cycle, so the flash restarts
                    if (start_read)
                        read_scheduled <= 1'b1;
                    state <= RD_READING;
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_addr)
            active_addr <= addr;
    end

endmodule

`default_nettype wire

/* qspi_flash.sv */
`timescale 1ns/1ns
`default_nettype none

module qspi_flash (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [flash_pkg::FLASH_ADDR_BITS-1:0] addr,
    input  logic                                 do_read,
    input  logic [3:0]                           io_in,
    output logic                                 setup_done,
    output logic                                 byte_valid,
    output logic [7:0]                           byte_data,
    output logic                                 cs,
    output logic                                 sclk,
    output logic [3:0]                           io_out,
    output logic [3:0]                           io_oe
);
    import flash_pkg::*;

    logic [2:0]      state;
    logic [2:0]      cnt;
    logic [3:0]      hi_nib;
    flash_cmd_word_u word;
    logic            in_txn;

    // Phases in which a read transaction holds cs low
    assign in_txn = (state == QS_CMD_ADDR) || (state == QS_DUMMY) || (state == QS_DATA);

    // sclk idles high. Every phase below toggles it once per clk, so one sclk period
    // takes two clk cycles. Outputs move on the falling half, inputs are taken on the
    // rising half
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= QS_WAKE;
            cnt        <= 3'd0;
            cs         <= 1'b1;
            sclk       <= 1'b1;
            io_out     <= 4'h0;
            io_oe      <= 4'h0;
            setup_done <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (in_txn && !do_read) begin
                // Read no longer wanted, release the bus with sclk back at idle
                state <= QS_END;
                cs    <= 1'b1;
                sclk  <= 1'b1;
                io_oe <= 4'h0;
            end else begin
                case (state)
                    QS_WAKE: begin
                        if (sclk) begin
                            // Single-line SPI, WP and HOLD driven high, MSB first
                            cs     <= 1'b0;
                            sclk   <= 1'b0;
                            io_oe  <= 4'b1101;
                            io_out <= {2'b11, 1'b0, CMD_WAKE[3'd7 - cnt]};
                        end else begin
                            sclk <= 1'b1;
                            cnt  <= cnt + 3'd1;
                            if (cnt == 3'd7)
                                state <= QS_WAKE_GAP;
                        end
                    end
                    QS_WAKE_GAP: begin
                        // One idle sclk period with cs high after the wake-up command
                        if (cnt == 3'd0) begin
                            cs    <= 1'b1;
                            io_oe <= 4'h0;
                            cnt   <= 3'd1;
                        end else begin
                            setup_done <= 1'b1;
                            cnt        <= 3'd0;
                            state      <= QS_IDLE;
                        end
                    end
                    QS_IDLE: begin
                        if (do_read) begin
                            cs          <= 1'b0;
                            word.f.cmd  <= CMD_QUAD_READ;
                            word.f.addr <= addr;
                            cnt         <= 3'd0;
                            state       <= QS_CMD_ADDR;
                        end
                    end
                    QS_CMD_ADDR: begin
                        if (sclk) begin
                            sclk     <= 1'b0;
                            io_oe    <= 4'hf;
                            io_out   <= word.nib[7];
                            word.nib <= {word.nib[6:0], 4'h0};
                        end else begin
                            sclk <= 1'b1;
                            cnt  <= cnt + 3'd1;
                            // Eight nibbles, the counter wraps back to zero for DUMMY
                            if (cnt == 3'd7)
                                state <= QS_DUMMY;
                        end
                    end
                    QS_DUMMY: begin
                        if (sclk) begin
                            sclk  <= 1'b0;
                            io_oe <= 4'h0;
                        end else begin
                            sclk <= 1'b1;
                            if (cnt == 3'(DUMMY_CLKS - 1)) begin
                                cnt   <= 3'd0;
                                state <= QS_DATA;
                            end else begin
                                cnt <= cnt + 3'd1;
                            end
                        end
                    end
                    QS_DATA: begin
                        if (sclk) begin
                            sclk <= 1'b0;
                        end else begin
                            sclk <= 1'b1;
                            cnt  <= cnt + 3'd1;
                            // High nibble comes first on the lines
                            if (!cnt[0])
                                hi_nib <= io_in;
                            else
                                byte_valid <= 1'b1;
                        end
                    end
                    QS_END: begin
                        // cs has been high for this cycle and the next one
                        state <= QS_IDLE;
                    end
                    default: begin
                        state <= QS_END;
                        cs    <= 1'b1;
                        sclk  <= 1'b1;
                        io_oe <= 4'h0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == QS_DATA && do_read && !sclk && cnt[0])
            byte_data <= {hi_nib, io_in};
    end

endmodule

`default_nettype wire

/* sources.f */
flash_pkg.sv
qspi_flash.sv
flash_reader.sv
fetch_port.sv
flash_fetch_top.sv
flash_model.sv
flash_checker.sv
flash_fetch_properties.sv
tb_flash_fetch.sv

/* tb_flash_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_flash_fetch;
    import flash_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int N_RANDOM    = 40;
    localparam int N_RUNS      = 6;
    localparam int RUN_LEN     = 8;
    localparam int N_SLOW      = 20;
    localparam int N_JUMPS     = 8;
    localparam int N_REQS      = N_RANDOM + N_RUNS * RUN_LEN + N_SLOW + 3 * N_JUMPS;
    // A miss takes about 40 cycles, the slow client adds up to 40 more
    localparam int REQ_CYCLES  = 100;
    localparam int WATCHDOG_NS = (N_REQS * REQ_CYCLES + 100) * CLK_NS;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic                       req = 1'b0;
    logic [FLASH_ADDR_BITS-1:0] addr = '0;
    logic [3:0]                 io_in;
    logic                       ack;
    logic [7:0]                 data;
    logic                       cs;
    logic                       sclk;
    logic [3:0]                 io_out;
    logic [3:0]                 io_oe;
    integer                     seed = 32'h293d;
    int                         base_checks = 0;
    int                         base_errors = 0;
    int                         prop_fails;
    logic [FLASH_ADDR_BITS-1:0] start;

    always #(CLK_NS / 2) clk = ~clk;

    flash_fetch_top dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .addr   (addr),
        .io_in  (io_in),
        .ack    (ack),
        .data   (data),
        .cs     (cs),
        .sclk   (sclk),
        .io_out (io_out),
        .io_oe  (io_oe)
    );

    flash_model u_model (
        .cs     (cs),
        .sclk   (sclk),
        .io_out (io_out),
        .io_in  (io_in)
    );

    flash_checker u_checker (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .addr  (addr),
        .ack   (ack),
        .data  (data),
        .cs    (cs),
        .io_oe (io_oe)
    );

    function automatic logic [FLASH_ADDR_BITS-1:0] random_addr();
        logic [31:0] r;
        r = $random(seed);
        return r[FLASH_ADDR_BITS-1:0];
    endfunction

    function automatic int random_delay(input int max);
        return $unsigned($random(seed)) % (max + 1);
    endfunction

    // One full four-phase transfer, with optional idle cycles before and a late req drop
    task automatic fetch(input logic [FLASH_ADDR_BITS-1:0] a, input int hold, input int gap);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        addr <= a;
        req  <= 1'b1;
        do @(posedge clk); while (!ack);
        repeat (hold) @(posedge clk);
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    task automatic report_test(input string name);
        @(negedge clk);
        $display("test %s: %0d checks, %0d errors", name, u_checker.checks - base_checks,
                 u_checker.errors - base_errors);
        base_checks = u_checker.checks;
        base_errors = u_checker.errors;
    endtask

    initial begin
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (30) @(posedge clk);
        report_test("reset");

        for (int i = 0; i < N_RANDOM; i++)
            fetch(random_addr(), 0, 0);
        report_test("random");

        for (int r = 0; r < N_RUNS; r++) begin
            start = random_addr();
            for (int i = 0; i < RUN_LEN; i++)
                fetch(start + FLASH_ADDR_BITS'(i), 0, 0);
        end
        report_test("sequential");

        start = random_addr();
        for (int i = 0; i < N_SLOW; i++) begin
            // Mostly sequential, so buffer hits also meet the delays
            if (random_delay(3) != 0)
                start = start + 24'd1;
            else
                start = random_addr();
            fetch(start, random_delay(20), random_delay(20));
        end
        report_test("slow client");

        for (int j = 0; j < N_JUMPS; j++) begin
            start = random_addr();
            fetch(start, 0, 0);
            fetch(start + 24'd1, 0, 0);
            // The prefetch of start+2 is still in flight here
            fetch(start ^ 24'h800000, 0, 0);
        end
        report_test("jumps");

        prop_fails = dut.u_props.fail_count;
        $display("summary: %0d requests, %0d checks, %0d errors, %0d assertion failures",
                 N_REQS, u_checker.checks, u_checker.errors, prop_fails);
        if (u_checker.errors == 0 && prop_fails == 0 && u_checker.checks > 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns, a request got no ack",
                 WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
